//--- src/adc_link_pkg.sv
// adc link package with sample format, host opcodes, reply bytes and controller states
package adc_link_pkg;

    // serial adc frame
    localparam int SAMPLE_W       = 10;
    localparam int ADC_FRAME_LEN  = 16;  // sclk periods with cs low
    localparam int ADC_DATA_FIRST = 4;   // data in periods 4..13, msb first

    // host command opcodes
    typedef enum logic [7:0] {
        CMD_PING   = 8'h50,  // 'P'
        CMD_SAMPLE = 8'h53   // 'S'
    } cmd_t;

    localparam logic [7:0] REPLY_HEADER = 8'h41;  // 'A', leads every reply
    localparam logic [2:0] PREFIX_LO    = 3'b100;
    localparam logic [2:0] PREFIX_HI    = 3'b110;

    // reply sequencer states
    typedef enum logic [2:0] {
        IDLE,
        SEND_HDR,
        SEND_LO,
        SEND_HI,
        WAIT_TX
    } ctrl_state_t;

endpackage

//--- src/adc_sampler.sv
// adc sampler that drives chip select and serial clock and shifts in one sample per frame
`timescale 1ns/10ps

module adc_sampler #(
    parameter int SCLK_HALF = 7
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              adc_sdata,
    output logic                              adc_cs_n,
    output logic                              adc_sclk,
    output logic [adc_link_pkg::SAMPLE_W-1:0] sample,
    output logic                              sample_valid
);
    import adc_link_pkg::*;

    localparam int HW          = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;
    localparam int NUM_PERIODS = ADC_FRAME_LEN + 2;  // frame plus idle gap
    localparam int PW          = $clog2(NUM_PERIODS);

    localparam logic [HW-1:0] HALF_LAST   = HW'(SCLK_HALF - 1);
    localparam logic [PW-1:0] PERIOD_LAST = PW'(NUM_PERIODS - 1);
    localparam logic [PW-1:0] FRAME_LEN   = PW'(ADC_FRAME_LEN);
    localparam logic [PW-1:0] DATA_FIRST  = PW'(ADC_DATA_FIRST);
    localparam logic [PW-1:0] DATA_LAST   = PW'(ADC_DATA_FIRST + SAMPLE_W - 1);

    logic [HW-1:0]       half_cnt;
    logic                second_half;  // high half of the sclk period
    logic [PW-1:0]       period;
    logic                half_tick;
    logic                in_frame;
    logic                capture;
    logic                last_capture;
    logic [SAMPLE_W-2:0] shift_q;

    assign half_tick = (half_cnt == HALF_LAST);
    assign in_frame  = (period < FRAME_LEN);

    // sclk rises on the edge that ends the low half
    assign capture      = half_tick && !second_half && in_frame
                          && (period >= DATA_FIRST) && (period <= DATA_LAST);
    assign last_capture = capture && (period == DATA_LAST);

    assign adc_cs_n = !in_frame;
    assign adc_sclk = !(in_frame && !second_half);  // parks high outside the frame

    // half-period divider and period counter
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            half_cnt    <= '0;
            second_half <= 1'b0;
            period      <= FRAME_LEN;  // begin in the idle gap
        end else if (half_tick) begin
            half_cnt    <= '0;
            second_half <= !second_half;
            if (second_half) begin
                period <= (period == PERIOD_LAST) ? '0 : period + 1'b1;
            end
        end else begin
            half_cnt <= half_cnt + 1'b1;
        end
    end

    // msb first capture
    always_ff @(posedge clk) begin
        if (capture) begin
            shift_q <= {shift_q[SAMPLE_W-3:0], adc_sdata};
        end
        if (last_capture) begin
            sample <= {shift_q, adc_sdata};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= last_capture;  // lines up with the new sample
        end
    end

endmodule

//--- src/uart_rx.sv
// uart receiver for 8n1 bytes with mid-bit sampling and stop-bit check
`timescale 1ns/10ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       uart_rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    localparam logic [CW-1:0] BIT_LAST  = CW'(CLKS_PER_BIT - 1);
    localparam logic [CW-1:0] HALF_LAST = CW'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t     state;
    logic [CW-1:0] clk_cnt;
    logic [2:0]    bit_idx;
    logic          rxd_meta;
    logic          rxd_sync;
    logic          rxd_prev;
    logic [7:0]    shift_q;
    logic          sample_now;

    // two flop synchronizer plus one flop of history for the start edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= uart_rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    // half a bit into the start bit, then whole bits
    assign sample_now = (state == RX_START) ? (clk_cnt == HALF_LAST) : (clk_cnt == BIT_LAST);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= RX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            clk_cnt  <= sample_now ? '0 : clk_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (rxd_prev && !rxd_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (sample_now) begin
                        state <= rxd_sync ? RX_IDLE : RX_DATA;  // glitch rejected
                    end
                end
                RX_DATA: begin
                    if (sample_now) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                default: begin
                    if (sample_now) begin
                        rx_valid <= rxd_sync;  // framing error drops the byte
                        state    <= RX_IDLE;
                    end
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == RX_DATA && sample_now) begin
            shift_q <= {rxd_sync, shift_q[7:1]};
        end
    end

    assign rx_data = shift_q;

endmodule

//--- src/uart_tx.sv
// uart transmitter sending one 8n1 byte per start pulse
`timescale 1ns/10ps

module uart_tx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       uart_txd,
    output logic       tx_busy
);

    localparam int CW = $clog2(CLKS_PER_BIT + 1);

    localparam logic [CW-1:0] BIT_LAST = CW'(CLKS_PER_BIT - 1);

    typedef enum logic {
        TX_IDLE,
        TX_SHIFT
    } tx_state_t;

    tx_state_t     state;
    logic [CW-1:0] clk_cnt;
    logic [3:0]    bit_idx;
    logic [9:0]    frame_q;  // stop, data, start
    logic          bit_done;

    assign bit_done = (clk_cnt == BIT_LAST);
    assign tx_busy  = (state == TX_SHIFT);
    assign uart_txd = (state == TX_SHIFT) ? frame_q[0] : 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= TX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else if (state == TX_IDLE) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            if (tx_start) begin
                state <= TX_SHIFT;
            end
        end else if (bit_done) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 4'd9) begin
                state <= TX_IDLE;  // end of stop bit
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_start) begin
            frame_q <= {1'b1, tx_data, 1'b0};
        end else if (state == TX_SHIFT && bit_done) begin
            frame_q <= {1'b1, frame_q[9:1]};
        end
    end

endmodule

//--- src/link_controller.sv
// link controller that buffers samples, decodes host commands and sequences reply bytes
`timescale 1ns/10ps

module link_controller (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [adc_link_pkg::SAMPLE_W-1:0] sample,
    input  logic                              sample_valid,
    input  logic [7:0]                        rx_data,
    input  logic                              rx_valid,
    input  logic                              tx_busy,
    output logic [7:0]                        tx_data,
    output logic                              tx_start
);
    import adc_link_pkg::*;

    localparam int LO_W = SAMPLE_W / 2;  // bits per reply half

    ctrl_state_t         state;
    ctrl_state_t         next_send;  // where WAIT_TX goes once the byte is out
    logic [SAMPLE_W-1:0] sample_buf;
    logic [SAMPLE_W-1:0] reply_q;

    // latest conversion
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            sample_buf <= sample;
        end
    end

    // freeze the value for the whole reply
    always_ff @(posedge clk) begin
        if (state == IDLE && rx_valid) begin
            reply_q <= sample_buf;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            next_send <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (rx_valid) begin
                        case (cmd_t'(rx_data))
                            CMD_SAMPLE: begin
                                state     <= SEND_HDR;
                                next_send <= SEND_LO;
                            end
                            CMD_PING: begin
                                state     <= SEND_HDR;
                                next_send <= IDLE;  // header only
                            end
                            default: state <= IDLE;
                        endcase
                    end
                end
                SEND_HDR: state <= WAIT_TX;
                SEND_LO: begin
                    state     <= WAIT_TX;
                    next_send <= SEND_HI;
                end
                SEND_HI: begin
                    state     <= WAIT_TX;
                    next_send <= IDLE;
                end
                default: begin
                    if (!tx_busy) begin
                        state <= next_send;
                    end
                end
            endcase
        end
    end

    // one start pulse per send state, tx is idle by then
    assign tx_start = (state == SEND_HDR) || (state == SEND_LO) || (state == SEND_HI);

    always_comb begin
        case (state)
            SEND_LO: tx_data = {PREFIX_LO, reply_q[LO_W-1:0]};
            SEND_HI: tx_data = {PREFIX_HI, reply_q[SAMPLE_W-1:LO_W]};
            default: tx_data = REPLY_HEADER;
        endcase
    end

endmodule

//--- src/adc_link_top.sv
// adc link top joining the adc sampler, uart receiver, link controller and uart transmitter
`timescale 1ns/10ps

module adc_link_top #(
    parameter int CLKS_PER_BIT = 868,
    parameter int SCLK_HALF    = 7
) (
    input  logic clk,
    input  logic arst_n,
    input  logic adc_sdata,
    input  logic uart_rxd,
    output logic adc_cs_n,
    output logic adc_sclk,
    output logic uart_txd
);
    import adc_link_pkg::*;

    logic [SAMPLE_W-1:0] sample;
    logic                sample_valid;
    logic [7:0]          rx_data;
    logic                rx_valid;
    logic [7:0]          tx_data;
    logic                tx_start;
    logic                tx_busy;

    adc_sampler #(
        .SCLK_HALF (SCLK_HALF)
    ) u_adc_sampler (
        .clk          (clk),
        .arst_n       (arst_n),
        .adc_sdata    (adc_sdata),
        .adc_cs_n     (adc_cs_n),
        .adc_sclk     (adc_sclk),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_rx (
        .clk      (clk),
        .arst_n   (arst_n),
        .uart_rxd (uart_rxd),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    link_controller u_link_controller (
        .clk          (clk),
        .arst_n       (arst_n),
        .sample       (sample),
        .sample_valid (sample_valid),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .tx_busy      (tx_busy),
        .tx_data      (tx_data),
        .tx_start     (tx_start)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_tx (
        .clk      (clk),
        .arst_n   (arst_n),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .uart_txd (uart_txd),
        .tx_busy  (tx_busy)
    );

endmodule

//--- tb/serial_models.sv
// behavioral serial adc and host uart models for the adc link testbench
`timescale 1ns/10ps

module tb_serial_models #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                              clk,
    input  logic                              adc_cs_n,
    input  logic                              adc_sclk,
    input  logic [adc_link_pkg::SAMPLE_W-1:0] adc_value,
    input  logic                              uart_txd,
    output logic                              adc_sdata,
    output logic                              uart_rxd
);
    import adc_link_pkg::*;

    int                  fall_cnt;  // sclk falls seen in this frame
    int                  period;
    logic [SAMPLE_W-1:0] shifted;

    initial begin
        adc_sdata = 1'b0;
        uart_rxd  = 1'b1;  // line idles high
        fall_cnt  = 0;
    end

    always @(posedge adc_cs_n) begin
        fall_cnt = 0;
    end

    // each falling sclk opens a period, the bit is ready well before the rise
    always @(negedge adc_sclk) begin
        period   = fall_cnt;
        fall_cnt = fall_cnt + 1;
        #1;
        shifted = adc_value << (period - ADC_DATA_FIRST);
        if (period >= ADC_DATA_FIRST && period < ADC_DATA_FIRST + SAMPLE_W) begin
            adc_sdata = shifted[SAMPLE_W-1];  // msb first
        end else begin
            adc_sdata = 1'b0;
        end
    end

    // one 8n1 byte from the host, stop level selectable
    task automatic send_byte(input logic [7:0] data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        repeat (10) begin
            @(posedge clk);
            #1 uart_rxd = frame[0];
            frame = frame >> 1;
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
        @(posedge clk);
        #1 uart_rxd = 1'b1;
    endtask

    // waits for a start bit and samples every bit at its middle
    task automatic recv_byte(output logic [7:0] data, output logic stop_ok);
        data = '0;
        @(negedge clk);
        while (uart_txd !== 1'b0) @(negedge clk);
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        repeat (8) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            data = {uart_txd, data[7:1]};  // lsb first
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        stop_ok = (uart_txd === 1'b1);
    endtask

endmodule

//--- tb/tb_adc_link.sv
// testbench for the adc link with adc and host models, reply checker and watchdog
`timescale 1ns/10ps

module tb_adc_link;
    import adc_link_pkg::*;

    localparam int BIT_CLKS   = 16;
    localparam int SCLK_HALF  = 3;
    localparam int FRAME_BITS = ((ADC_FRAME_LEN + 2) * 2 * SCLK_HALF) / BIT_CLKS + 1;
    localparam int SETTLE     = 3 * FRAME_BITS + 1;  // three frames before a command
    localparam int CMD_BITS   = 11;
    localparam int REPLY_BITS = 30;
    localparam int QUIET_BITS = 30;
    localparam int TOTAL_BITS = 4 * FRAME_BITS
                                + 6 * (SETTLE + CMD_BITS + REPLY_BITS + QUIET_BITS)
                                + 3 * (CMD_BITS + QUIET_BITS)
                                + 2 * (SETTLE + 2 * CMD_BITS + REPLY_BITS + QUIET_BITS)
                                + QUIET_BITS;

    localparam logic [7:0] SAMPLE_CMD  = 8'h53;
    localparam logic [7:0] PING_CMD    = 8'h50;
    localparam logic [7:0] HEADER_BYTE = 8'h41;

    typedef logic [7:0] byte_q_t[$];

    logic                clk;
    logic                arst_n;
    logic                adc_sdata;
    logic                uart_rxd;
    logic                adc_cs_n;
    logic                adc_sclk;
    logic                uart_txd;
    logic [SAMPLE_W-1:0] adc_value;
    logic [31:0]         lfsr;
    logic                mon_en;
    byte_q_t             exp_q;  // bytes still owed by the DUT
    int                  value_errs = 0;
    int                  other_errs = 0;
    int                  rises = 0;       // sclk rises since monitoring began
    int                  frame_mark = 0;  // rise count at the last frame end

    adc_link_top #(
        .CLKS_PER_BIT (BIT_CLKS),
        .SCLK_HALF    (SCLK_HALF)
    ) u_adc_link_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .adc_sdata (adc_sdata),
        .uart_rxd  (uart_rxd),
        .adc_cs_n  (adc_cs_n),
        .adc_sclk  (adc_sclk),
        .uart_txd  (uart_txd)
    );

    tb_serial_models #(
        .CLKS_PER_BIT (BIT_CLKS)
    ) u_models (
        .clk       (clk),
        .adc_cs_n  (adc_cs_n),
        .adc_sclk  (adc_sclk),
        .adc_value (adc_value),
        .uart_txd  (uart_txd),
        .adc_sdata (adc_sdata),
        .uart_rxd  (uart_rxd)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic byte_q_t expected_reply(input logic [7:0] cmd, input logic [9:0] value);
        byte_q_t q;
        q = {};
        if (cmd == SAMPLE_CMD) begin
            q.push_back(HEADER_BYTE);
            q.push_back({3'b100, value[4:0]});
            q.push_back({3'b110, value[9:5]});
        end else if (cmd == PING_CMD) begin
            q.push_back(HEADER_BYTE);  // ping echoes the header only
        end
        return q;
    endfunction

    task automatic check_level(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("FAIL %0t: %s is %b, expected %b", $time, name, got, want);
            value_errs++;
        end
    endtask

    task automatic check_idle_lines();
        check_level("uart_txd", uart_txd, 1'b1);
        check_level("adc_cs_n", adc_cs_n, 1'b1);
        check_level("adc_sclk", adc_sclk, 1'b1);
    endtask

    // new model value, then let three whole frames refresh the buffer
    task automatic new_value();
        repeat (SAMPLE_W) begin
            lfsr = lfsr_step(lfsr);
            adc_value = {adc_value[SAMPLE_W-2:0], lfsr[0]};
        end
        repeat (3) @(posedge adc_cs_n);
    endtask

    task automatic push_expected(input logic [7:0] cmd);
        byte_q_t q;
        q = expected_reply(cmd, adc_value);
        foreach (q[i]) begin
            exp_q.push_back(q[i]);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 2 * REPLY_BITS * BIT_CLKS) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("reply incomplete at %0t, %0d bytes never arrived", $time, exp_q.size());
            other_errs++;
            exp_q.delete();
        end
    endtask

    task automatic wait_quiet();
        logic seen;
        seen = 1'b0;
        repeat (QUIET_BITS * BIT_CLKS) begin
            @(negedge clk);
            if (uart_txd === 1'b0 && !seen) begin
                $display("unexpected start bit on uart_txd at %0t", $time);
                other_errs++;
                seen = 1'b1;
            end
        end
    endtask

    task automatic run_cmd(input logic [7:0] cmd);
        push_expected(cmd);
        u_models.send_byte(cmd, 1'b1);
        wait_drain();
        wait_quiet();
    endtask

    // adc frame shape
    always @(posedge adc_sclk) begin
        if (mon_en) begin
            if (adc_cs_n) begin
                $display("adc_sclk rose while adc_cs_n was high at %0t", $time);
                other_errs++;
            end else begin
                rises++;
            end
        end
    end

    always @(posedge adc_cs_n) begin
        if (mon_en && rises - frame_mark != ADC_FRAME_LEN) begin
            $display("FAIL %0t: frame had %0d sclk rises, expected %0d", $time,
                     rises - frame_mark, ADC_FRAME_LEN);
            value_errs++;
        end
        frame_mark = rises;
    end

    // every byte on uart_txd against the owed list
    initial begin : compare_replies
        logic [7:0] got;
        logic       stop_ok;
        logic [7:0] want;
        @(posedge arst_n);
        forever begin
            u_models.recv_byte(got, stop_ok);
            if (!stop_ok) begin
                $display("reply byte %02h at %0t has a low stop bit", got, $time);
                other_errs++;
            end
            if (exp_q.size() == 0) begin
                $display("unexpected reply byte %02h at %0t", got, $time);
                other_errs++;
            end else begin
                want = exp_q.pop_front();
                if (got !== want) begin
                    $display("FAIL %0t: reply byte expected %02h, received %02h", $time, want,
                             got);
                    value_errs++;
                end
            end
        end
    end

    initial begin
        repeat (2 * TOTAL_BITS * BIT_CLKS + 1000) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        arst_n    = 1'b0;
        adc_value = '0;
        lfsr      = 32'hca4b_f35b;
        mon_en    = 1'b0;
        repeat (2) @(negedge clk);
        check_idle_lines();  // inside reset
        repeat (6) @(posedge clk);
        #1 arst_n = 1'b1;
        mon_en = 1'b1;
        repeat (2) @(negedge clk);
        check_idle_lines();  // one edge out of reset

        repeat (4) @(posedge adc_cs_n);

        repeat (5) begin
            new_value();
            run_cmd(SAMPLE_CMD);
        end

        new_value();
        run_cmd(PING_CMD);
        run_cmd(8'h00);
        run_cmd(8'hff);
        run_cmd(8'h41);

        // ping during a sample reply is dropped
        new_value();
        push_expected(SAMPLE_CMD);
        u_models.send_byte(SAMPLE_CMD, 1'b1);
        u_models.send_byte(PING_CMD, 1'b1);
        wait_drain();
        wait_quiet();

        new_value();
        u_models.send_byte(SAMPLE_CMD, 1'b0);  // bad stop bit
        wait_quiet();
        run_cmd(SAMPLE_CMD);

        $display("errors: %0d value, %0d other", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
src/adc_link_pkg.sv
src/adc_sampler.sv
src/uart_rx.sv
src/uart_tx.sv
src/link_controller.sv
src/adc_link_top.sv
tb/serial_models.sv
tb/tb_adc_link.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the adc link testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/Vtb_adc_link

verilator --binary --timing --timescale 1ns/10ps -f list.f --top-module tb_adc_link
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
    exit 1
fi
exit 0
